// File: Bender.yml
package:
  name: sup_csr_file

sources:
  - include_dirs:
      - source
    files:
      - source/csr_pkg.sv
      - source/csr_write_stage.sv
      - source/csr_bank.sv
      - source/csr_read_guard.sv
      - source/sup_csr_file.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/sup_csr_file_sva.sv
      - testbench/sup_csr_file_tb.sv

// File: flist.f
+incdir+source
source/csr_pkg.sv
source/csr_write_stage.sv
source/csr_bank.sv
source/csr_read_guard.sv
source/sup_csr_file.sv
testbench/sup_csr_file_sva.sv
testbench/sup_csr_file_tb.sv

// File: source/csr_bank.sv
`default_nettype none

`include "csr_params.svh"

module csr_bank (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         wr_commit_i,
  input  wire csr_pkg::csr_wr_req_t   wr_req_i,
  input  wire csr_pkg::csr_exc_t      exc_i,
  input  wire [`COMMIT_CNT_WIDTH-1:0] commit_cnt_i,
  input  wire                         sret_i,
  input  wire [`CSR_WIDTH-1:0]        fflags_acc_i,
  input  wire [`CSR_ADDR_WIDTH-1:0]   rd_addr_i,
  input  wire [`CSR_ADDR_WIDTH-1:0]   chk_addr_i,
  output logic [`CSR_WIDTH-1:0]       rd_data_o,
  output logic [`CSR_WIDTH-1:0]       chk_data_o,
  output logic [`CSR_WIDTH-1:0]       epc_o,
  output logic [`CSR_WIDTH-1:0]       evec_o,
  output logic [`CSR_WIDTH-1:0]       status_o,
  output logic [`CSR_WIDTH-1:0]       frm_o
);

  import csr_pkg::*;

  logic [`CSR_WIDTH-1:0] fflags_q;
  logic [`CSR_WIDTH-1:0] frm_q;
  logic [`CSR_WIDTH-1:0] epc_q;
  logic [`CSR_WIDTH-1:0] badvaddr_q;
  logic [`CSR_WIDTH-1:0] count_q;
  logic [`CSR_WIDTH-1:0] evec_q;
  logic [`CSR_WIDTH-1:0] cause_q;
  csr_status_u           status_q;

  logic [`CSR_WIDTH-1:0] badvaddr_next;
  logic [`CSR_WIDTH-1:0] count_next;
  csr_status_u           status_next;
  csr_status_u           status_wr;

  // address decode of the committed write
  logic wr_fflags;
  logic wr_frm;
  logic wr_epc;
  logic wr_badvaddr;
  logic wr_count;
  logic wr_evec;
  logic wr_cause;
  logic wr_status;

  assign wr_fflags   = wr_commit_i && (wr_req_i.addr == `CSR_ADDR_FFLAGS);
  assign wr_frm      = wr_commit_i && (wr_req_i.addr == `CSR_ADDR_FRM);
  assign wr_epc      = wr_commit_i && (wr_req_i.addr == `CSR_ADDR_EPC);
  assign wr_badvaddr = wr_commit_i && (wr_req_i.addr == `CSR_ADDR_BADVADDR);
  assign wr_count    = wr_commit_i && (wr_req_i.addr == `CSR_ADDR_COUNT);
  assign wr_evec     = wr_commit_i && (wr_req_i.addr == `CSR_ADDR_EVEC);
  assign wr_cause    = wr_commit_i && (wr_req_i.addr == `CSR_ADDR_CAUSE);
  assign wr_status   = wr_commit_i && (wr_req_i.addr == `CSR_ADDR_STATUS);

  // retired instructions plus one for the excepting instruction
  assign count_next = count_q
                    + {{(`CSR_WIDTH-`COMMIT_CNT_WIDTH){1'b0}}, commit_cnt_i}
                    + {{(`CSR_WIDTH-1){1'b0}}, exc_i.valid};

  // faulting address source follows the cause class
  always_comb
  begin
    badvaddr_next = badvaddr_q;
    if (exc_i.valid)
    begin
      case (exc_i.cause)
        `CAUSE_MISALIGNED_FETCH,
        `CAUSE_FAULT_FETCH:      badvaddr_next = exc_i.pc;
        `CAUSE_MISALIGNED_LOAD,
        `CAUSE_FAULT_LOAD:       badvaddr_next = exc_i.ld_addr;
        `CAUSE_MISALIGNED_STORE,
        `CAUSE_FAULT_STORE:      badvaddr_next = exc_i.st_addr;
        default:                 badvaddr_next = badvaddr_q;
      endcase
    end
  end

  // sret pops the previous privilege and interrupt enable
  always_comb
  begin
    status_next = status_q;
    if (sret_i)
    begin
      status_next.f.s  = status_q.f.ps;
      status_next.f.ei = status_q.f.pei;
    end
  end

  // software cannot touch IP, masked bits read zero
  always_comb
  begin
    status_wr.raw  = wr_req_i.data;
    status_wr.f.ip = status_q.f.ip;
    status_wr.raw  = status_wr.raw & `CSR_STATUS_MASK;
  end

  // a committed write beats the hardware update of the same register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fflags_q     <= '0;
      frm_q        <= '0;
      epc_q        <= '0;
      badvaddr_q   <= '0;
      count_q      <= '0;
      evec_q       <= '0;
      cause_q      <= '0;
      status_q.raw <= `CSR_STATUS_RESET;
    end
    else
    begin
      fflags_q     <= wr_fflags ? wr_req_i.data : (fflags_q | fflags_acc_i);
      frm_q        <= wr_frm ? wr_req_i.data : frm_q;
      epc_q        <= wr_epc ? wr_req_i.data : (exc_i.valid ? exc_i.pc : epc_q);
      badvaddr_q   <= wr_badvaddr ? wr_req_i.data : badvaddr_next;
      count_q      <= wr_count ? wr_req_i.data : count_next;
      evec_q       <= wr_evec ? wr_req_i.data : evec_q;
      if (wr_cause)
        cause_q <= wr_req_i.data;
      else if (exc_i.valid)
        cause_q <= {{(`CSR_WIDTH-`CAUSE_WIDTH){1'b0}}, exc_i.cause};
      status_q.raw <= wr_status ? status_wr.raw : status_next.raw;
    end
  end

  // pipeline read port
  always_comb
  begin
    case (rd_addr_i)
      `CSR_ADDR_FFLAGS:   rd_data_o = fflags_q;
      `CSR_ADDR_FRM:      rd_data_o = frm_q;
      `CSR_ADDR_EPC:      rd_data_o = epc_q;
      `CSR_ADDR_BADVADDR: rd_data_o = badvaddr_q;
      `CSR_ADDR_COUNT:    rd_data_o = count_q;
      `CSR_ADDR_EVEC:     rd_data_o = evec_q;
      `CSR_ADDR_CAUSE:    rd_data_o = cause_q;
      `CSR_ADDR_STATUS:   rd_data_o = status_q.raw;
      default:            rd_data_o = '0;
    endcase
  end

  // checkpoint compare port
  always_comb
  begin
    case (chk_addr_i)
      `CSR_ADDR_FFLAGS:   chk_data_o = fflags_q;
      `CSR_ADDR_FRM:      chk_data_o = frm_q;
      `CSR_ADDR_EPC:      chk_data_o = epc_q;
      `CSR_ADDR_BADVADDR: chk_data_o = badvaddr_q;
      `CSR_ADDR_COUNT:    chk_data_o = count_q;
      `CSR_ADDR_EVEC:     chk_data_o = evec_q;
      `CSR_ADDR_CAUSE:    chk_data_o = cause_q;
      `CSR_ADDR_STATUS:   chk_data_o = status_q.raw;
      default:            chk_data_o = '0;
    endcase
  end

  assign epc_o    = epc_q;
  assign evec_o   = evec_q;
  assign status_o = status_q.raw;
  assign frm_o    = frm_q;

endmodule

`default_nettype wire

// File: source/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// datapath widths
`define CSR_WIDTH         32
`define CSR_ADDR_WIDTH    12
`define PC_WIDTH          32
`define CAUSE_WIDTH       4
// up to four instructions retire per cycle
`define COMMIT_CNT_WIDTH  3

// implemented register addresses
`define CSR_ADDR_FFLAGS   `CSR_ADDR_WIDTH'h001
`define CSR_ADDR_FRM      `CSR_ADDR_WIDTH'h002
`define CSR_ADDR_EPC      `CSR_ADDR_WIDTH'h502
`define CSR_ADDR_BADVADDR `CSR_ADDR_WIDTH'h503
`define CSR_ADDR_COUNT    `CSR_ADDR_WIDTH'h506
`define CSR_ADDR_EVEC     `CSR_ADDR_WIDTH'h508
`define CSR_ADDR_CAUSE    `CSR_ADDR_WIDTH'h509
`define CSR_ADDR_STATUS   `CSR_ADDR_WIDTH'h50a

// exception causes that carry a faulting address
`define CAUSE_MISALIGNED_FETCH `CAUSE_WIDTH'd0
`define CAUSE_FAULT_FETCH      `CAUSE_WIDTH'd1
`define CAUSE_MISALIGNED_LOAD  `CAUSE_WIDTH'd4
`define CAUSE_MISALIGNED_STORE `CAUSE_WIDTH'd5
`define CAUSE_FAULT_LOAD       `CAUSE_WIDTH'd6
`define CAUSE_FAULT_STORE      `CAUSE_WIDTH'd7

// status field positions, S sits at bit 0 and the flags follow upward
`define CSR_STATUS_EA_BIT 8
`define CSR_STATUS_IM_LSB 16
`define CSR_STATUS_IP_LSB 24

// writable status bits, EA and bits 9..15 always read zero
`define CSR_STATUS_MASK   `CSR_WIDTH'hffff00ff

// S, U64 and S64 set out of reset
`define CSR_STATUS_RESET  `CSR_WIDTH'h00000061

`endif

// File: source/csr_pkg.sv
`default_nettype none

`include "csr_params.svh"

package csr_pkg;

  // write held until the CSR instruction commits
  typedef struct packed {
    logic [`CSR_ADDR_WIDTH-1:0] addr;
    logic [`CSR_WIDTH-1:0]      data;
  } csr_wr_req_t;

  // exception report from retire
  typedef struct packed {
    logic                    valid;
    logic [`PC_WIDTH-1:0]    pc;
    logic [`CAUSE_WIDTH-1:0] cause;
    logic [`PC_WIDTH-1:0]    ld_addr;
    logic [`PC_WIDTH-1:0]    st_addr;
  } csr_exc_t;

  // status register fields, msb first
  typedef struct packed {
    logic [`CSR_WIDTH-`CSR_STATUS_IP_LSB-1:0]         ip;
    logic [`CSR_STATUS_IP_LSB-`CSR_STATUS_IM_LSB-1:0] im;
    logic [`CSR_STATUS_IM_LSB-`CSR_STATUS_EA_BIT-2:0] zero;
    logic                                             ea;
    logic                                             vm;
    logic                                             s64;
    logic                                             u64;
    logic                                             ef;
    logic                                             pei;
    logic                                             ei;
    logic                                             ps;
    logic                                             s;
  } csr_status_t;

  // status is stored as a word but merged and restored by field
  typedef union packed {
    logic [`CSR_WIDTH-1:0] raw;
    csr_status_t           f;
  } csr_status_u;

endpackage

`default_nettype wire

// File: source/csr_read_guard.sv
`default_nettype none

`include "csr_params.svh"

module csr_read_guard (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        rd_en_i,
  input  wire [`CSR_ADDR_WIDTH-1:0]  rd_addr_i,
  input  wire [`CSR_WIDTH-1:0]       rd_data_i,
  input  wire                        flush_i,
  input  wire                        commit_i,
  input  wire [`CSR_WIDTH-1:0]       chk_data_i,
  output logic [`CSR_ADDR_WIDTH-1:0] chk_addr_o,
  output logic                       atomic_vio_o
);

  logic [`CSR_ADDR_WIDTH-1:0] chk_addr_q;
  logic [`CSR_WIDTH-1:0]      chk_data_q;
  logic                       chk_valid_q;

  // snapshot of what the CSR instruction read
  always_ff @(posedge clk)
  begin
    if (rd_en_i)
    begin
      chk_addr_q <= rd_addr_i;
      chk_data_q <= rd_data_i;
    end
  end

  // a new read re-arms even if it coincides with flush or commit
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      chk_valid_q <= 1'b0;
    else if (rd_en_i)
      chk_valid_q <= 1'b1;
    else if (flush_i || commit_i)
      chk_valid_q <= 1'b0;
  end

  assign chk_addr_o = chk_addr_q;

  // the bank returns zero on both ports for unimplemented addresses,
  // so those reads never mismatch
  assign atomic_vio_o = chk_valid_q && (chk_data_i != chk_data_q);

endmodule

`default_nettype wire

// File: source/csr_write_stage.sv
`default_nettype none

`include "csr_params.svh"

module csr_write_stage (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        wr_en_i,
  input  wire [`CSR_ADDR_WIDTH-1:0]  wr_addr_i,
  input  wire [`CSR_WIDTH-1:0]       wr_data_i,
  input  wire                        flush_i,
  input  wire                        commit_i,
  output csr_pkg::csr_wr_req_t       wr_req_o,
  output logic                       wr_commit_o
);

  import csr_pkg::*;

  csr_wr_req_t wr_req_q;
  logic        pending_q;

  // capture the most recent write request
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      wr_req_q.addr <= wr_addr_i;
      wr_req_q.data <= wr_data_i;
    end
  end

  // a new write wins over a flush in the same cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pending_q <= 1'b0;
    else if (wr_en_i)
      pending_q <= 1'b1;
    else if (flush_i)
      pending_q <= 1'b0;
  end

  assign wr_req_o = wr_req_q;

  // a flushed request never reaches the bank
  assign wr_commit_o = commit_i & pending_q;

endmodule

`default_nettype wire

// File: source/sup_csr_file.sv
`default_nettype none

`include "csr_params.svh"

module sup_csr_file (
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         flush_i,
  input  wire                         commit_i,
  input  wire                         wr_en_i,
  input  wire [`CSR_ADDR_WIDTH-1:0]   wr_addr_i,
  input  wire [`CSR_WIDTH-1:0]        wr_data_i,
  input  wire                         rd_en_i,
  input  wire [`CSR_ADDR_WIDTH-1:0]   rd_addr_i,
  input  wire csr_pkg::csr_exc_t      exc_i,
  input  wire [`COMMIT_CNT_WIDTH-1:0] commit_cnt_i,
  input  wire                         sret_i,
  input  wire [`CSR_WIDTH-1:0]        fflags_acc_i,
  output logic [`CSR_WIDTH-1:0]       rd_data_o,
  output logic                        atomic_vio_o,
  output logic [`CSR_WIDTH-1:0]       epc_o,
  output logic [`CSR_WIDTH-1:0]       evec_o,
  output logic [`CSR_WIDTH-1:0]       status_o,
  output logic [`CSR_WIDTH-1:0]       frm_o
);

  import csr_pkg::*;

  csr_wr_req_t                wr_req;
  logic                       wr_commit;
  logic [`CSR_ADDR_WIDTH-1:0] chk_addr;
  logic [`CSR_WIDTH-1:0]      chk_data;

  csr_write_stage u_write_stage (
    .clk         (clk),
    .reset       (reset),
    .wr_en_i     (wr_en_i),
    .wr_addr_i   (wr_addr_i),
    .wr_data_i   (wr_data_i),
    .flush_i     (flush_i),
    .commit_i    (commit_i),
    .wr_req_o    (wr_req),
    .wr_commit_o (wr_commit)
  );

  csr_bank u_bank (
    .clk          (clk),
    .reset        (reset),
    .wr_commit_i  (wr_commit),
    .wr_req_i     (wr_req),
    .exc_i        (exc_i),
    .commit_cnt_i (commit_cnt_i),
    .sret_i       (sret_i),
    .fflags_acc_i (fflags_acc_i),
    .rd_addr_i    (rd_addr_i),
    .chk_addr_i   (chk_addr),
    .rd_data_o    (rd_data_o),
    .chk_data_o   (chk_data),
    .epc_o        (epc_o),
    .evec_o       (evec_o),
    .status_o     (status_o),
    .frm_o        (frm_o)
  );

  // the guard snapshots the same word the pipeline sees
  csr_read_guard u_read_guard (
    .clk          (clk),
    .reset        (reset),
    .rd_en_i      (rd_en_i),
    .rd_addr_i    (rd_addr_i),
    .rd_data_i    (rd_data_o),
    .flush_i      (flush_i),
    .commit_i     (commit_i),
    .chk_data_i   (chk_data),
    .chk_addr_o   (chk_addr),
    .atomic_vio_o (atomic_vio_o)
  );

endmodule

`default_nettype wire

// File: testbench/sup_csr_file_sva.sv
`default_nettype none

module sup_csr_file_sva (
  input wire clk,
  input wire reset,
  input wire wr_en_i,
  input wire wr_commit_i,
  input wire flush_i,
  input wire rd_en_i,
  input wire atomic_vio_i
);

  // a flushed write never reaches the bank on a later commit
  a_no_commit_after_flush: assert property (
    @(posedge clk) disable iff (reset) (flush_i && !wr_en_i) |=> !wr_commit_i
  ) else $error("commit pulse reached the bank after its write was flushed");

  a_vio_low_in_reset: assert property (
    @(posedge clk) reset |-> !atomic_vio_i
  ) else $error("atomic_vio_o high while reset is asserted");

  // flush without a new read disarms the checkpoint
  a_flush_clears_vio: assert property (
    @(posedge clk) disable iff (reset) (flush_i && !rd_en_i) |=> !atomic_vio_i
  ) else $error("atomic_vio_o still high the cycle after a flush");

endmodule

bind sup_csr_file sup_csr_file_sva u_sva (
  .clk          (clk),
  .reset        (reset),
  .wr_en_i      (wr_en_i),
  .wr_commit_i  (wr_commit),
  .flush_i      (flush_i),
  .rd_en_i      (rd_en_i),
  .atomic_vio_i (atomic_vio_o)
);

`default_nettype wire

// File: testbench/sup_csr_file_tb.sv
`default_nettype none

`include "csr_params.svh"

module sup_csr_file_tb;

  import csr_pkg::*;

  // one table row is one clock cycle of stimulus plus what it should read back
  typedef struct packed {
    logic                         wr_en;
    logic [`CSR_ADDR_WIDTH-1:0]   wr_addr;
    logic [`CSR_WIDTH-1:0]        wr_data;
    logic                         commit;
    logic                         flush;
    logic                         rd_en;
    logic [`CSR_ADDR_WIDTH-1:0]   rd_addr;
    csr_exc_t                     exc;
    logic [`COMMIT_CNT_WIDTH-1:0] commit_cnt;
    logic                         sret;
    logic [`CSR_WIDTH-1:0]        fflags_acc;
    logic [`CSR_WIDTH-1:0]        exp_rd;
    logic                         exp_vio;
  } row_t;

  logic                         clk;
  logic                         reset;
  logic                         flush;
  logic                         commit;
  logic                         wr_en;
  logic [`CSR_ADDR_WIDTH-1:0]   wr_addr;
  logic [`CSR_WIDTH-1:0]        wr_data;
  logic                         rd_en;
  logic [`CSR_ADDR_WIDTH-1:0]   rd_addr;
  csr_exc_t                     exc;
  logic [`COMMIT_CNT_WIDTH-1:0] commit_cnt;
  logic                         sret;
  logic [`CSR_WIDTH-1:0]        fflags_acc;
  logic [`CSR_WIDTH-1:0]        rd_data;
  logic                         atomic_vio;
  logic [`CSR_WIDTH-1:0]        epc;
  logic [`CSR_WIDTH-1:0]        evec;
  logic [`CSR_WIDTH-1:0]        status;
  logic [`CSR_WIDTH-1:0]        frm;

  row_t                  table_q[$];
  int                    err_rd;
  int                    err_vio;
  int                    err_out;
  int                    cycle_cnt;
  int                    cycle_limit;
  logic [`CSR_WIDTH-1:0] rnd_evec;
  logic [`CSR_WIDTH-1:0] rnd_status;

  sup_csr_file u_dut (
    .clk          (clk),
    .reset        (reset),
    .flush_i      (flush),
    .commit_i     (commit),
    .wr_en_i      (wr_en),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .rd_en_i      (rd_en),
    .rd_addr_i    (rd_addr),
    .exc_i        (exc),
    .commit_cnt_i (commit_cnt),
    .sret_i       (sret),
    .fflags_acc_i (fflags_acc),
    .rd_data_o    (rd_data),
    .atomic_vio_o (atomic_vio),
    .epc_o        (epc),
    .evec_o       (evec),
    .status_o     (status),
    .frm_o        (frm)
  );

  always #4 clk = ~clk;

  function automatic row_t blank_row(input logic [`CSR_ADDR_WIDTH-1:0] raddr,
                                     input logic [`CSR_WIDTH-1:0] exp, input logic vio);
    row_t r;
    r = '0;
    r.rd_addr = raddr;
    r.exp_rd  = exp;
    r.exp_vio = vio;
    return r;
  endfunction

  task automatic add_read(input logic [11:0] raddr, input logic [31:0] exp, input logic vio);
    table_q.push_back(blank_row(raddr, exp, vio));
  endtask

  task automatic add_write(input logic [11:0] waddr, input logic [31:0] wdata,
                           input logic [11:0] raddr, input logic [31:0] exp);
    row_t r;
    r = blank_row(raddr, exp, 1'b0);
    r.wr_en   = 1'b1;
    r.wr_addr = waddr;
    r.wr_data = wdata;
    table_q.push_back(r);
  endtask

  task automatic add_ctrl(input logic cmt, input logic fl, input logic ren,
                          input logic [11:0] raddr, input logic [31:0] exp, input logic vio);
    row_t r;
    r = blank_row(raddr, exp, vio);
    r.commit = cmt;
    r.flush  = fl;
    r.rd_en  = ren;
    table_q.push_back(r);
  endtask

  task automatic add_exc(input logic [31:0] pc, input logic [3:0] cause, input logic [31:0] ld,
                         input logic [31:0] st, input logic [2:0] cnt,
                         input logic [11:0] raddr, input logic [31:0] exp);
    row_t r;
    r = blank_row(raddr, exp, 1'b0);
    r.exc.valid   = 1'b1;
    r.exc.pc      = pc;
    r.exc.cause   = cause;
    r.exc.ld_addr = ld;
    r.exc.st_addr = st;
    r.commit_cnt  = cnt;
    table_q.push_back(r);
  endtask

  task automatic add_misc(input logic [2:0] cnt, input logic sr, input logic [31:0] ff,
                          input logic [11:0] raddr, input logic [31:0] exp);
    row_t r;
    r = blank_row(raddr, exp, 1'b0);
    r.commit_cnt = cnt;
    r.sret       = sr;
    r.fflags_acc = ff;
    table_q.push_back(r);
  endtask

  task automatic apply_row(input row_t r);
    wr_en      <= r.wr_en;
    wr_addr    <= r.wr_addr;
    wr_data    <= r.wr_data;
    commit     <= r.commit;
    flush      <= r.flush;
    rd_en      <= r.rd_en;
    rd_addr    <= r.rd_addr;
    exc        <= r.exc;
    commit_cnt <= r.commit_cnt;
    sret       <= r.sret;
    fflags_acc <= r.fflags_acc;
  endtask

  task automatic check_row(input int idx, input row_t r);
    if (rd_data !== r.exp_rd)
    begin
      err_rd++;
      $display("Fail time=%0t row %0d rd_data_o expected %h actual %h",
               $time, idx, r.exp_rd, rd_data);
    end
    if (atomic_vio !== r.exp_vio)
    begin
      err_vio++;
      $display("Fail time=%0t row %0d atomic_vio_o expected %b actual %b",
               $time, idx, r.exp_vio, atomic_vio);
    end
    // the pipeline outputs carry the same register as the read port
    if (r.rd_addr == `CSR_ADDR_EPC && epc !== r.exp_rd)
    begin
      err_out++;
      $display("Fail time=%0t row %0d epc_o expected %h actual %h",
               $time, idx, r.exp_rd, epc);
    end
    if (r.rd_addr == `CSR_ADDR_EVEC && evec !== r.exp_rd)
    begin
      err_out++;
      $display("Fail time=%0t row %0d evec_o expected %h actual %h",
               $time, idx, r.exp_rd, evec);
    end
    if (r.rd_addr == `CSR_ADDR_STATUS && status !== r.exp_rd)
    begin
      err_out++;
      $display("Fail time=%0t row %0d status_o expected %h actual %h",
               $time, idx, r.exp_rd, status);
    end
    if (r.rd_addr == `CSR_ADDR_FRM && frm !== r.exp_rd)
    begin
      err_out++;
      $display("Fail time=%0t row %0d frm_o expected %h actual %h",
               $time, idx, r.exp_rd, frm);
    end
  endtask

  // each row is one cycle, expected values reflect the rows before it
  task automatic build_table();
    add_read(`CSR_ADDR_STATUS, `CSR_STATUS_RESET, 1'b0);
    add_read(`CSR_ADDR_FFLAGS, 32'h0, 1'b0);
    add_read(`CSR_ADDR_FRM, 32'h0, 1'b0);
    add_read(`CSR_ADDR_EPC, 32'h0, 1'b0);
    add_read(`CSR_ADDR_BADVADDR, 32'h0, 1'b0);
    add_read(`CSR_ADDR_COUNT, 32'h0, 1'b0);
    add_read(`CSR_ADDR_EVEC, 32'h0, 1'b0);
    add_read(`CSR_ADDR_CAUSE, 32'h0, 1'b0);
    add_read(12'h7c0, 32'h0, 1'b0);
    // staged writes only show after commit
    add_write(`CSR_ADDR_EVEC, rnd_evec, `CSR_ADDR_EVEC, 32'h0);
    add_read(`CSR_ADDR_EVEC, 32'h0, 1'b0);
    add_ctrl(1'b1, 1'b0, 1'b0, `CSR_ADDR_EVEC, 32'h0, 1'b0);
    add_read(`CSR_ADDR_EVEC, rnd_evec, 1'b0);
    add_write(`CSR_ADDR_FRM, 32'h3, `CSR_ADDR_FRM, 32'h0);
    add_ctrl(1'b1, 1'b0, 1'b0, `CSR_ADDR_FRM, 32'h0, 1'b0);
    add_read(`CSR_ADDR_FRM, 32'h3, 1'b0);
    add_write(`CSR_ADDR_STATUS, rnd_status, `CSR_ADDR_STATUS, `CSR_STATUS_RESET);
    add_ctrl(1'b1, 1'b0, 1'b0, `CSR_ADDR_STATUS, `CSR_STATUS_RESET, 1'b0);
    // IP and bits 8..15 read as zero
    add_read(`CSR_ADDR_STATUS, rnd_status & ~32'hff00ff00, 1'b0);
    // flushed write is lost
    add_write(`CSR_ADDR_EVEC, 32'hdead0000, `CSR_ADDR_EVEC, rnd_evec);
    add_ctrl(1'b0, 1'b1, 1'b0, `CSR_ADDR_EVEC, rnd_evec, 1'b0);
    add_ctrl(1'b1, 1'b0, 1'b0, `CSR_ADDR_EVEC, rnd_evec, 1'b0);
    add_read(`CSR_ADDR_EVEC, rnd_evec, 1'b0);
    // load fault, then store fault, then a cause without an address
    add_exc(32'h80001000, 4'd6, 32'h40000010, 32'h50000010, 3'd0, `CSR_ADDR_EPC, 32'h0);
    add_read(`CSR_ADDR_EPC, 32'h80001000, 1'b0);
    add_read(`CSR_ADDR_CAUSE, 32'h6, 1'b0);
    add_read(`CSR_ADDR_BADVADDR, 32'h40000010, 1'b0);
    add_exc(32'h80002000, 4'd7, 32'h40000020, 32'h50000020, 3'd0, `CSR_ADDR_COUNT, 32'h1);
    add_read(`CSR_ADDR_BADVADDR, 32'h50000020, 1'b0);
    add_misc(3'd3, 1'b0, 32'h0, `CSR_ADDR_COUNT, 32'h2);
    add_exc(32'h80003000, 4'd9, 32'h40000030, 32'h50000030, 3'd2, `CSR_ADDR_COUNT, 32'h5);
    add_read(`CSR_ADDR_COUNT, 32'h8, 1'b0);
    add_read(`CSR_ADDR_BADVADDR, 32'h50000020, 1'b0);
    // sticky fflags
    add_misc(3'd0, 1'b0, 32'h1, `CSR_ADDR_FFLAGS, 32'h0);
    add_misc(3'd0, 1'b0, 32'h4, `CSR_ADDR_FFLAGS, 32'h1);
    add_read(`CSR_ADDR_FFLAGS, 32'h5, 1'b0);
    // PS and EI set, PEI and S clear, then sret
    add_write(`CSR_ADDR_STATUS, 32'h66, `CSR_ADDR_STATUS, rnd_status & ~32'hff00ff00);
    add_ctrl(1'b1, 1'b0, 1'b0, `CSR_ADDR_STATUS, rnd_status & ~32'hff00ff00, 1'b0);
    add_read(`CSR_ADDR_STATUS, 32'h66, 1'b0);
    add_misc(3'd0, 1'b1, 32'h0, `CSR_ADDR_STATUS, 32'h66);
    add_read(`CSR_ADDR_STATUS, 32'h63, 1'b0);
    // epc changes under a checkpointed read
    add_ctrl(1'b0, 1'b0, 1'b1, `CSR_ADDR_EPC, 32'h80003000, 1'b0);
    add_exc(32'h80004000, 4'd6, 32'h40000040, 32'h50000040, 3'd0, `CSR_ADDR_EPC, 32'h80003000);
    add_read(`CSR_ADDR_EPC, 32'h80004000, 1'b1);
    add_ctrl(1'b0, 1'b1, 1'b0, `CSR_ADDR_EPC, 32'h80004000, 1'b1);
    add_read(`CSR_ADDR_EPC, 32'h80004000, 1'b0);
    // a register that holds still never flags
    add_ctrl(1'b0, 1'b0, 1'b1, `CSR_ADDR_FRM, 32'h3, 1'b0);
    add_read(`CSR_ADDR_FRM, 32'h3, 1'b0);
    add_ctrl(1'b1, 1'b0, 1'b0, `CSR_ADDR_FRM, 32'h3, 1'b0);
    add_read(`CSR_ADDR_FRM, 32'h3, 1'b0);
  endtask

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("timeout: the table did not finish within %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial
  begin
    clk        = 1'b0;
    reset      = 1'b1;
    flush      = 1'b0;
    commit     = 1'b0;
    wr_en      = 1'b0;
    wr_addr    = '0;
    wr_data    = '0;
    rd_en      = 1'b0;
    rd_addr    = '0;
    exc        = '0;
    commit_cnt = '0;
    sret       = 1'b0;
    fflags_acc = '0;
    err_rd     = 0;
    err_vio    = 0;
    err_out    = 0;
    cycle_cnt  = 0;
    void'($urandom(69419));
    rnd_evec   = $urandom();
    rnd_status = $urandom();
    build_table();
    // reset cycles plus the table plus margin
    cycle_limit = 3 + table_q.size() + 20;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    foreach (table_q[i])
    begin
      @(posedge clk);
      apply_row(table_q[i]);
      @(negedge clk);
      check_row(i, table_q[i]);
    end
    $display("errors: %0d total, rd_data_o %0d, atomic_vio_o %0d, pipeline outputs %0d",
             err_rd + err_vio + err_out, err_rd, err_vio, err_out);
    if (err_rd + err_vio + err_out == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire
